// ==== src/stream_pkg.sv ====
////////////////////////////////////////
// shared widths and encodings for the stream splitter
// referenced by scoped names from every block
////////////////////////////////////////
`default_nettype none

package stream_pkg;

    // beat and length widths
    localparam int DATA_W = 16;
    localparam int LEN_W  = 16;

    // command word is opcode on top of a length field
    localparam int CMD_W = 2 + LEN_W;

    // chunk length used until the host programs one
    localparam logic [LEN_W-1:0] RESET_LEN = LEN_W'(4);

    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,
        CMD_SET_LEN = 2'd1,
        CMD_OPEN    = 2'd2,
        CMD_CLOSE   = 2'd3
    } cmd_op_e;

    typedef enum logic [1:0] {
        VALVE_OPEN   = 2'd0,
        VALVE_DRAIN  = 2'd1,
        VALVE_CLOSED = 2'd2
    } valve_state_e;

endpackage

`default_nettype wire

// ==== src/axis_if.sv ====
////////////////////////////////////////
// valid/ready stream between the internal blocks
// source drives the beat, sink drives ready
////////////////////////////////////////
`default_nettype none

interface axis_if;

    logic                         valid;
    logic                         ready;
    logic [stream_pkg::DATA_W-1:0] data;
    // marks the final beat of a chunk
    logic                         last;

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// ==== src/len_cmd_decode.sv ====
////////////////////////////////////////
// command port decode for the splitter
// holds the chunk length, pulses open and close requests
////////////////////////////////////////
`default_nettype none

module len_cmd_decode (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             cmd_valid,
    input  logic [stream_pkg::CMD_W-1:0]     cmd_word,
    output logic [stream_pkg::LEN_W-1:0]     chunk_len,
    output logic                             open_req,
    output logic                             close_req
);

    stream_pkg::cmd_op_e              cmd_op;
    logic [stream_pkg::LEN_W-1:0]     len_field;
    logic [stream_pkg::LEN_W-1:0]     len_clamped;

    // opcode sits in the top two bits
    assign cmd_op    = stream_pkg::cmd_op_e'(cmd_word[stream_pkg::CMD_W-1 -: 2]);
    assign len_field = cmd_word[stream_pkg::LEN_W-1:0];

    // a zero length would never close a chunk, treat it as one
    assign len_clamped = (len_field == '0) ? stream_pkg::LEN_W'(1) : len_field;

    // held chunk length
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            chunk_len <= stream_pkg::RESET_LEN;
        end else if (cmd_valid && (cmd_op == stream_pkg::CMD_SET_LEN)) begin
            chunk_len <= len_clamped;
        end
    end

    // single cycle request strobes for the valve
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            open_req  <= 1'b0;
            close_req <= 1'b0;
        end else begin
            open_req  <= 1'b0;
            close_req <= 1'b0;
            if (cmd_valid) begin
                case (cmd_op)
                    stream_pkg::CMD_OPEN: begin
                        open_req <= 1'b1;
                    end
                    stream_pkg::CMD_CLOSE: begin
                        close_req <= 1'b1;
                    end
                    default: begin
                        // nop and set_len raise no request
                        open_req  <= 1'b0;
                        close_req <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_partition.sv ====
////////////////////////////////////////
// one register stage that cuts the stream into chunks
// regenerates last at each chunk end, warns before the end
////////////////////////////////////////
`default_nettype none

module stream_partition (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [stream_pkg::DATA_W-1:0]    in_data,
    input  logic                             in_last,
    input  logic [stream_pkg::LEN_W-1:0]     chunk_len,
    output logic                             req_new_len,
    axis_if.source                           part_out
);

    logic                             accept;
    logic                             first_beat;
    logic                             chunk_end;
    logic [stream_pkg::LEN_W-1:0]     beat_cnt;
    logic [stream_pkg::LEN_W-1:0]     active_len;
    logic [stream_pkg::LEN_W-1:0]     cur_len;
    logic [stream_pkg::LEN_W-1:0]     len_minus_1;
    logic [stream_pkg::LEN_W-1:0]     len_minus_2;

    // stage is free when empty or draining this cycle
    assign in_ready = !part_out.valid || part_out.ready;
    assign accept   = in_valid && in_ready;

    // first beat of a chunk picks up the length programmed right now
    assign first_beat = (beat_cnt == '0);
    assign cur_len    = first_beat ? chunk_len : active_len;

    assign len_minus_1 = cur_len - stream_pkg::LEN_W'(1);
    assign len_minus_2 = cur_len - stream_pkg::LEN_W'(2);

    // chunk closes on a full count or on the upstream last flag
    assign chunk_end = in_last || (beat_cnt == len_minus_1);

    // beat position and latched length
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt   <= '0;
            active_len <= stream_pkg::RESET_LEN;
        end else if (accept) begin
            if (first_beat) begin
                active_len <= chunk_len;
            end
            if (chunk_end) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + stream_pkg::LEN_W'(1);
            end
        end
    end

    // output valid holds until the beat is taken
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            part_out.valid <= 1'b0;
        end else if (accept) begin
            part_out.valid <= 1'b1;
        end else if (part_out.ready) begin
            part_out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            part_out.last <= 1'b0;
        end else if (accept) begin
            part_out.last <= chunk_end;
        end
    end

    // payload register
    always_ff @(posedge clock) begin
        if (accept) begin
            part_out.data <= in_data;
        end
    end

    // next accepted beat will close the chunk, give the host a cycle
    // to load another length
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            req_new_len <= 1'b0;
        end else begin
            req_new_len <= accept && !chunk_end && (beat_cnt == len_minus_2);
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_valve.sv ====
////////////////////////////////////////
// output valve, opens at once and closes on a chunk boundary
// zero latency, gates both valid and ready
////////////////////////////////////////
`default_nettype none

module stream_valve (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             open_req,
    input  logic                             close_req,
    axis_if.sink                             part_in,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [stream_pkg::DATA_W-1:0]    out_data,
    output logic                             out_last
);

    stream_pkg::valve_state_e state;
    stream_pkg::valve_state_e state_next;
    logic                     pass;
    logic                     xfer;
    logic                     in_chunk;
    logic                     in_chunk_next;

    assign pass = (state != stream_pkg::VALVE_CLOSED);

    assign out_valid     = part_in.valid && pass;
    assign part_in.ready = out_ready && pass;
    assign out_data      = part_in.data;
    assign out_last      = part_in.last;

    assign xfer = part_in.valid && out_ready && pass;

    // chunk status including the beat moving this cycle
    assign in_chunk_next = xfer ? !part_in.last : in_chunk;

    always_comb begin
        state_next = state;
        if (open_req) begin
            state_next = stream_pkg::VALVE_OPEN;
        end else begin
            case (state)
                stream_pkg::VALVE_OPEN: begin
                    if (close_req) begin
                        // idle between chunks closes straight away
                        state_next = in_chunk_next ? stream_pkg::VALVE_DRAIN
                                                   : stream_pkg::VALVE_CLOSED;
                    end
                end
                stream_pkg::VALVE_DRAIN: begin
                    if (xfer && part_in.last) begin
                        state_next = stream_pkg::VALVE_CLOSED;
                    end
                end
                default: begin
                    state_next = stream_pkg::VALVE_CLOSED;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= stream_pkg::VALVE_CLOSED;
            in_chunk <= 1'b0;
        end else begin
            state    <= state_next;
            in_chunk <= in_chunk_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_splitter_top.sv ====
////////////////////////////////////////
// stream splitter top level
// command decode, chunk partition and output valve in series
////////////////////////////////////////
`default_nettype none

module stream_splitter_top (
    input  logic                             clock,
    input  logic                             rst_n,
    // command port
    input  logic                             cmd_valid,
    input  logic [stream_pkg::CMD_W-1:0]     cmd_word,
    // input stream
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [stream_pkg::DATA_W-1:0]    in_data,
    input  logic                             in_last,
    // output stream
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [stream_pkg::DATA_W-1:0]    out_data,
    output logic                             out_last,
    output logic                             req_new_len
);

    logic [stream_pkg::LEN_W-1:0] chunk_len;
    logic                         open_req;
    logic                         close_req;

    axis_if part_to_valve ();

    len_cmd_decode u_decode (
        .clock     (clock),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),
        .chunk_len (chunk_len),
        .open_req  (open_req),
        .close_req (close_req)
    );

    stream_partition u_partition (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .in_last     (in_last),
        .chunk_len   (chunk_len),
        .req_new_len (req_new_len),
        .part_out    (part_to_valve.source)
    );

    // valve sits last so a close never splits a chunk on the output
    stream_valve u_valve (
        .clock     (clock),
        .rst_n     (rst_n),
        .open_req  (open_req),
        .close_req (close_req),
        .part_in   (part_to_valve.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

// ==== sim/tb_stream_splitter.sv ====
////////////////////////////////////////
// random traffic testbench for the stream splitter
// queue model of chunking, valve and length commands
////////////////////////////////////////
`default_nettype none

module tb_stream_splitter;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 5000;

    logic                          clock;
    logic                          rst_n;
    logic                          cmd_valid;
    logic [stream_pkg::CMD_W-1:0]  cmd_word;
    logic                          in_valid;
    logic                          in_ready;
    logic [stream_pkg::DATA_W-1:0] in_data;
    logic                          in_last;
    logic                          out_valid;
    logic                          out_ready;
    logic [stream_pkg::DATA_W-1:0] out_data;
    logic                          out_last;
    logic                          req_new_len;

    // random source and driver state
    logic [31:0] lfsr_state;
    logic [31:0] rnd;
    logic        skip;
    logic        in_fire;
    int          pkts_left;
    int          pkt_len;
    int          pkt_idx;
    logic        pkt_active;
    int          force_len;
    logic        gap_en;
    logic        ready_rand;

    // reference model and monitor state
    logic [16:0] exp_q[$];
    logic [16:0] mon_beat;
    logic        mon_end;
    int          model_len;
    int          model_active;
    int          model_cnt;
    int          exp_req;
    int          got_req;
    int          in_cnt;
    int          out_cnt;
    logic        close_pending;
    logic        closed_flag;
    string       test_name;
    int          err_mismatch;
    int          err_other;

    stream_splitter_top i_stream_splitter_top (
        .clock       (clock),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .in_last     (in_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_last    (out_last),
        .req_new_len (req_new_len)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
            err_mismatch++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        err_other++;
        finish_run();
    endtask

    task automatic send_cmd(input stream_pkg::cmd_op_e op, input logic [15:0] len);
        @(posedge clock);
        cmd_valid <= 1'b1;
        cmd_word  <= {op, len};
        @(posedge clock);
        cmd_valid <= 1'b0;
        @(negedge clock);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!(pkts_left == 0 && !pkt_active && !in_valid && exp_q.size() == 0)) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("stream did not drain");
            end
        end
    endtask

    task automatic wait_out_count(input int n);
        int cycles;
        cycles = 0;
        while (out_cnt < n) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("too few output beats");
            end
        end
    endtask

    task automatic wait_closed();
        int cycles;
        cycles = 0;
        while (!closed_flag) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("no chunk end after the close command");
            end
        end
    endtask

    // a beat is held until the negedge sample saw it accepted
    always @(posedge clock) begin
        if (rst_n) begin
            if (ready_rand) begin
                draw_bits(1, rnd);
                out_ready <= rnd[0];
            end else begin
                out_ready <= 1'b1;
            end
            if (!in_valid || in_fire) begin
                if (!pkt_active && pkts_left > 0) begin
                    draw_bits(4, rnd);
                    pkt_len    = (force_len > 0) ? force_len : (rnd % 12) + 1;
                    pkt_idx    = 0;
                    pkt_active = 1'b1;
                    pkts_left--;
                end
                skip = 1'b0;
                if (gap_en) begin
                    draw_bits(2, rnd);
                    skip = (rnd[1:0] == 2'd0);
                end
                if (pkt_active && !skip) begin
                    draw_bits(stream_pkg::DATA_W, rnd);
                    in_valid <= 1'b1;
                    in_data  <= rnd[stream_pkg::DATA_W-1:0];
                    in_last  <= (pkt_idx == pkt_len - 1);
                    pkt_idx++;
                    if (pkt_idx == pkt_len) begin
                        pkt_active = 1'b0;
                    end
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // chunk model on accepted beats, compare on transferred beats
    always @(negedge clock) begin
        in_fire = rst_n && in_valid && in_ready;
        if (in_fire) begin
            if (model_cnt == 0) begin
                model_active = model_len;
            end
            mon_end = in_last || (model_cnt == model_active - 1);
            if (!mon_end && model_cnt == model_active - 2) begin
                exp_req++;
            end
            exp_q.push_back({mon_end, in_data});
            model_cnt = mon_end ? 0 : model_cnt + 1;
            in_cnt++;
        end
        if (rst_n && out_valid) begin
            if (closed_flag) begin
                $display("Error in %s: output valid while the valve is closed", test_name);
                err_other++;
            end
            if (out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error in %s: output beat that was never sent", test_name);
                    err_other++;
                end else begin
                    mon_beat = exp_q.pop_front();
                    check_value({test_name, " data"}, mon_beat[15:0], out_data);
                    check_value({test_name, " last"}, mon_beat[16], out_last);
                end
                out_cnt++;
                if (close_pending && out_last) begin
                    closed_flag   = 1'b1;
                    close_pending = 1'b0;
                end
            end
        end
        if (rst_n && req_new_len) begin
            got_req++;
        end
    end

    initial begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_word      = '0;
        in_valid      = 1'b0;
        in_data       = '0;
        in_last       = 1'b0;
        out_ready     = 1'b1;
        lfsr_state    = 32'hfc1e;
        in_fire       = 1'b0;
        pkts_left     = 0;
        pkt_active    = 1'b0;
        force_len     = 0;
        gap_en        = 1'b0;
        ready_rand    = 1'b0;
        model_len     = 4;
        model_cnt     = 0;
        close_pending = 1'b0;
        closed_flag   = 1'b0;
        err_mismatch  = 0;
        err_other     = 0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);

        // valve starts closed, only the register stage fills
        test_name   = "reset_closed";
        closed_flag = 1'b1;
        in_cnt      = 0;
        pkts_left   = 1;
        repeat (20) @(posedge clock);
        @(negedge clock);
        check_value("reset_closed accepted beats", 1, in_cnt);
        check_value("reset_closed in_ready", 0, in_ready);
        closed_flag = 1'b0;

        test_name = "chunking";
        send_cmd(stream_pkg::CMD_SET_LEN, 16'd5);
        model_len = 5;
        exp_req   = 0;
        got_req   = 0;
        send_cmd(stream_pkg::CMD_OPEN, 16'd0);
        gap_en    = 1'b1;
        pkts_left = 20;
        wait_idle();
        check_value("chunking req_new_len pulses", exp_req, got_req);

        test_name  = "backpressure";
        ready_rand = 1'b1;
        in_cnt     = 0;
        out_cnt    = 0;
        exp_req    = 0;
        got_req    = 0;
        pkts_left  = 20;
        wait_idle();
        check_value("backpressure beat count", in_cnt, out_cnt);
        check_value("backpressure req_new_len pulses", exp_req, got_req);
        ready_rand = 1'b0;

        // zero length is taken as one
        test_name = "len_change";
        send_cmd(stream_pkg::CMD_SET_LEN, 16'd0);
        model_len = 1;
        exp_req   = 0;
        got_req   = 0;
        pkts_left = 10;
        wait_idle();
        check_value("len_change len 1 req_new_len", exp_req, got_req);
        send_cmd(stream_pkg::CMD_SET_LEN, 16'd3);
        model_len = 3;
        exp_req   = 0;
        got_req   = 0;
        pkts_left = 10;
        wait_idle();
        check_value("len_change len 3 req_new_len", exp_req, got_req);

        // one 12 beat packet, close lands inside the first 8 beat chunk
        test_name = "valve_close";
        gap_en    = 1'b0;
        send_cmd(stream_pkg::CMD_SET_LEN, 16'd8);
        model_len = 8;
        force_len = 12;
        out_cnt   = 0;
        pkts_left = 1;
        wait_out_count(3);
        close_pending = 1'b1;
        send_cmd(stream_pkg::CMD_CLOSE, 16'd0);
        wait_closed();
        repeat (20) @(negedge clock);
        check_value("valve_close beats before close", 8, out_cnt);
        check_value("valve_close in_ready", 0, in_ready);
        closed_flag = 1'b0;
        send_cmd(stream_pkg::CMD_OPEN, 16'd0);
        wait_idle();
        check_value("valve_close total beats", 12, out_cnt);
        force_len = 0;

        finish_run();
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/stream_pkg.sv
src/axis_if.sv
src/len_cmd_decode.sv
src/stream_partition.sv
src/stream_valve.sv
src/stream_splitter_top.sv
sim/tb_stream_splitter.sv

// ==== Bender.yml ====
package:
  name: stream_splitter

sources:
  - src/stream_pkg.sv
  - src/axis_if.sv
  - src/len_cmd_decode.sv
  - src/stream_partition.sv
  - src/stream_valve.sv
  - src/stream_splitter_top.sv
  - target: simulation
    files:
      - sim/tb_stream_splitter.sv
